// File: hdl/axi_wr_stats_pkg.sv
`default_nettype none

package axi_wr_stats_pkg;

  localparam int stat_width = 32;
  localparam int strb_width = 4;
  localparam int len_width  = 8;
  localparam int stat_count = 25;
  localparam int bin_count  = 12;

  typedef logic [stat_width-1:0] stat_val_t;

  // readout order with the bins after the channel statistics
  typedef enum logic [7:0] {
    stat_aw_burst_cnt     = 8'd0,
    stat_aw_depth_max     = 8'd1,
    stat_aw_len_min       = 8'd2,
    stat_aw_len_max       = 8'd3,
    stat_aw_bytes_sum     = 8'd4,
    stat_aw_bytes_min     = 8'd5,
    stat_aw_bytes_max     = 8'd6,
    stat_w_burst_cnt      = 8'd7,
    stat_w_depth_max      = 8'd8,
    stat_w_beat_cnt       = 8'd9,
    stat_w_bytes_sum      = 8'd10,
    stat_w_bytes_min      = 8'd11,
    stat_w_bytes_max      = 8'd12,
    stat_bin_idle         = 8'd13,
    stat_bin_slow_data    = 8'd14,
    stat_bin_stall        = 8'd15,
    stat_bin_early_beat   = 8'd16,
    stat_bin_awr_early    = 8'd17,
    stat_bin_addr_stall   = 8'd18,
    stat_bin_data_lag     = 8'd19,
    stat_bin_addr_lag     = 8'd20,
    stat_bin_early_stall  = 8'd21,
    stat_bin_b_lag        = 8'd22,
    stat_bin_b_stall      = 8'd23,
    stat_bin_b_end        = 8'd24
  } stat_id_t;

  typedef enum logic [3:0] {
    bin_idle        = 4'd0,
    bin_slow_data   = 4'd1,
    bin_stall       = 4'd2,
    bin_early_beat  = 4'd3,
    bin_awr_early   = 4'd4,
    bin_addr_stall  = 4'd5,
    bin_data_lag    = 4'd6,
    bin_addr_lag    = 4'd7,
    bin_early_stall = 4'd8,
    bin_b_lag       = 4'd9,
    bin_b_stall     = 4'd10,
    bin_b_end       = 4'd11
  } bin_t;

  typedef struct packed {
    logic                 valid;
    logic                 ready;
    logic [len_width-1:0] len;
    logic [2:0]           size;
  } aw_chan_t;

  typedef struct packed {
    logic                  valid;
    logic                  ready;
    logic [strb_width-1:0] strb;
    logic                  last;
  } w_chan_t;

  typedef struct packed {
    logic valid;
    logic ready;
  } b_chan_t;

  typedef struct packed {
    stat_val_t burst_cnt;
    stat_val_t len_min;
    stat_val_t len_max;
    stat_val_t bytes_sum;
    stat_val_t bytes_min;
    stat_val_t bytes_max;
  } aw_stats_t;

  typedef struct packed {
    stat_val_t burst_cnt;
    stat_val_t beat_cnt;
    stat_val_t bytes_sum;
    stat_val_t bytes_min;
    stat_val_t bytes_max;
  } w_stats_t;

  typedef struct packed {
    logic      aw_busy;
    logic      w_busy;
    logic      in_progress;
    stat_val_t aw_depth_max;
    stat_val_t w_depth_max;
  } occ_t;

  typedef logic [bin_count-1:0][stat_width-1:0] bins_t;

endpackage

`default_nettype wire

// File: hdl/aw_stats.sv
`default_nettype none

module aw_stats (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         stat_clear,
  input  axi_wr_stats_pkg::aw_chan_t   aw,
  output axi_wr_stats_pkg::aw_stats_t  stats
);
  import axi_wr_stats_pkg::*;

  logic      accept;
  stat_val_t len_val;
  stat_val_t burst_bytes;

  assign accept  = aw.valid && aw.ready;
  assign len_val = stat_val_t'(aw.len);

  // total bytes moved by the burst
  assign burst_bytes = (len_val + stat_val_t'(1)) << aw.size;

  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      stats.burst_cnt <= '0;
      stats.len_min   <= '1;
      stats.len_max   <= '0;
      stats.bytes_sum <= '0;
      stats.bytes_min <= '1;
      stats.bytes_max <= '0;
    end else if (accept) begin
      stats.burst_cnt <= stats.burst_cnt + stat_val_t'(1);
      stats.bytes_sum <= stats.bytes_sum + burst_bytes;

      if (len_val < stats.len_min) begin
        stats.len_min <= len_val;
      end
      if (len_val > stats.len_max) begin
        stats.len_max <= len_val;
      end

      if (burst_bytes < stats.bytes_min) begin
        stats.bytes_min <= burst_bytes;
      end
      if (burst_bytes > stats.bytes_max) begin
        stats.bytes_max <= burst_bytes;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/w_stats.sv
`default_nettype none

module w_stats (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stat_clear,
  input  axi_wr_stats_pkg::w_chan_t   w,
  output axi_wr_stats_pkg::w_stats_t  stats
);
  import axi_wr_stats_pkg::*;

  logic      beat_accept;
  logic      burst_end;
  stat_val_t beat_bytes;

  assign beat_accept = w.valid && w.ready;
  assign burst_end   = beat_accept && w.last;

  // bytes written by this beat, one per set strobe bit
  always_comb begin
    beat_bytes = '0;
    for (int i = 0; i < strb_width; i++) begin
      beat_bytes = beat_bytes + stat_val_t'(w.strb[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      stats.burst_cnt <= '0;
      stats.beat_cnt  <= '0;
      stats.bytes_sum <= '0;
      stats.bytes_min <= '1;
      stats.bytes_max <= '0;
    end else begin
      if (burst_end) begin
        stats.burst_cnt <= stats.burst_cnt + stat_val_t'(1);
      end

      if (beat_accept) begin
        stats.beat_cnt  <= stats.beat_cnt + stat_val_t'(1);
        stats.bytes_sum <= stats.bytes_sum + beat_bytes;

        if (beat_bytes < stats.bytes_min) begin
          stats.bytes_min <= beat_bytes;
        end
        if (beat_bytes > stats.bytes_max) begin
          stats.bytes_max <= beat_bytes;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/wr_occupancy.sv
`default_nettype none

module wr_occupancy (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       stat_clear,
  input  axi_wr_stats_pkg::aw_chan_t aw,
  input  axi_wr_stats_pkg::w_chan_t  w,
  input  axi_wr_stats_pkg::b_chan_t  b,
  output axi_wr_stats_pkg::occ_t     occ
);
  import axi_wr_stats_pkg::*;

  logic      aw_accept;
  logic      w_end;
  logic      b_accept;
  stat_val_t aw_cnt;
  stat_val_t w_cnt;
  stat_val_t aw_cnt_next;
  stat_val_t w_cnt_next;

  assign aw_accept = aw.valid && aw.ready;
  assign w_end     = w.valid && w.ready && w.last;
  assign b_accept  = b.valid && b.ready;

  // aw counts from address accept, w from last beat, both retire on b
  assign aw_cnt_next = aw_cnt + stat_val_t'(aw_accept) - stat_val_t'(b_accept);
  assign w_cnt_next  = w_cnt + stat_val_t'(w_end) - stat_val_t'(b_accept);

  // outstanding counts follow the bus and are not touched by a clear
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_cnt          <= '0;
      w_cnt           <= '0;
      occ.in_progress <= 1'b0;
    end else begin
      aw_cnt <= aw_cnt_next;
      w_cnt  <= w_cnt_next;
      if (w.valid) begin
        occ.in_progress <= !(w.ready && w.last);
      end
    end
  end

  // peaks compare against the updated count so they land with it
  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      occ.aw_depth_max <= '0;
      occ.w_depth_max  <= '0;
    end else begin
      if (aw_cnt_next > occ.aw_depth_max) begin
        occ.aw_depth_max <= aw_cnt_next;
      end
      if (w_cnt_next > occ.w_depth_max) begin
        occ.w_depth_max <= w_cnt_next;
      end
    end
  end

  assign occ.aw_busy = (aw_cnt != '0);
  assign occ.w_busy  = (w_cnt != '0);

endmodule

`default_nettype wire

// File: hdl/wr_cycle_bins.sv
`default_nettype none

module wr_cycle_bins (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       stat_clear,
  input  axi_wr_stats_pkg::occ_t     occ,
  input  axi_wr_stats_pkg::aw_chan_t aw,
  input  axi_wr_stats_pkg::w_chan_t  w,
  input  axi_wr_stats_pkg::b_chan_t  b,
  output axi_wr_stats_pkg::bins_t    bin_cnt
);
  import axi_wr_stats_pkg::*;

  logic a_busy;
  logic w_busy;
  logic in_prog;
  logic aw_accept;
  logic w_accept;
  logic b_accept;
  logic hit;
  bin_t sel;

  assign a_busy    = occ.aw_busy;
  assign w_busy    = occ.w_busy;
  assign in_prog   = occ.in_progress;
  assign aw_accept = aw.valid && aw.ready;
  assign w_accept  = w.valid && w.ready;
  assign b_accept  = b.valid && b.ready;

  // first matching rule wins so at most one bin counts per cycle
  always_comb begin
    hit = 1'b1;
    sel = bin_idle;
    if (!a_busy && !w_busy && !in_prog && !aw.valid && !w.valid) begin
      sel = bin_idle;
    end else if (a_busy && in_prog && !w.valid) begin
      sel = bin_slow_data;
    end else if (a_busy && w.valid && !w.ready) begin
      sel = bin_stall;
    end else if (!a_busy && in_prog && w.valid && !w.ready) begin
      sel = bin_stall;
    end else if (!a_busy && !aw.valid && w_accept) begin
      sel = bin_early_beat;
    end else if (!a_busy && !w_busy && !in_prog && aw_accept && !w.valid) begin
      sel = bin_awr_early;
    end else if (!a_busy && !w_busy && !in_prog && aw.valid && !aw.ready && !w.valid) begin
      sel = bin_addr_stall;
    end else if (a_busy && !w_busy && !in_prog && !w.valid) begin
      sel = bin_data_lag;
    end else if (!a_busy && w_busy && !in_prog && !w.valid) begin
      sel = bin_addr_lag;
    end else if (!a_busy && in_prog && !w.valid) begin
      sel = bin_addr_lag;
    end else if (!a_busy && !in_prog && w.valid && !w.ready) begin
      sel = bin_early_stall;
    end else if (a_busy && w_busy && !in_prog && !w.valid && !b.valid) begin
      sel = bin_b_lag;
    end else if (a_busy && w_busy && !in_prog && !w.valid && b.valid && !b.ready) begin
      sel = bin_b_stall;
    end else if (a_busy && w_busy && !in_prog && !w.valid && b_accept) begin
      sel = bin_b_end;
    end else begin
      hit = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      bin_cnt <= '0;
    end else if (hit) begin
      bin_cnt[sel] <= bin_cnt[sel] + stat_val_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: hdl/stat_reader.sv
`default_nettype none

module stat_reader (
  input  logic                        clk,
  input  logic                        rst_n,
  input  axi_wr_stats_pkg::aw_stats_t aw_s,
  input  axi_wr_stats_pkg::w_stats_t  w_s,
  input  axi_wr_stats_pkg::occ_t      occ,
  input  axi_wr_stats_pkg::bins_t     bin_cnt,
  input  logic                        stat_start,
  input  logic                        stat_ready,
  output logic                        stat_valid,
  output axi_wr_stats_pkg::stat_id_t  stat_id,
  output axi_wr_stats_pkg::stat_val_t stat_val,
  output logic                        stat_last
);
  import axi_wr_stats_pkg::*;

  typedef enum logic {
    st_idle,
    st_iter
  } state_t;

  state_t     state;
  state_t     state_next;
  logic [7:0] idx;
  logic [7:0] idx_next;
  logic [7:0] bin_off;
  logic       at_last;
  logic       load;
  stat_val_t  sel_val;

  assign bin_off = idx - 8'(stat_bin_idle);
  assign at_last = (idx == 8'(stat_count - 1));

  // a new item loads when the output slot is empty or being taken
  assign load = (state == st_iter) && (!stat_valid || stat_ready);

  always_comb begin
    case (stat_id_t'(idx))
      stat_aw_burst_cnt: sel_val = aw_s.burst_cnt;
      stat_aw_depth_max: sel_val = occ.aw_depth_max;
      stat_aw_len_min:   sel_val = aw_s.len_min;
      stat_aw_len_max:   sel_val = aw_s.len_max;
      stat_aw_bytes_sum: sel_val = aw_s.bytes_sum;
      stat_aw_bytes_min: sel_val = aw_s.bytes_min;
      stat_aw_bytes_max: sel_val = aw_s.bytes_max;
      stat_w_burst_cnt:  sel_val = w_s.burst_cnt;
      stat_w_depth_max:  sel_val = occ.w_depth_max;
      stat_w_beat_cnt:   sel_val = w_s.beat_cnt;
      stat_w_bytes_sum:  sel_val = w_s.bytes_sum;
      stat_w_bytes_min:  sel_val = w_s.bytes_min;
      stat_w_bytes_max:  sel_val = w_s.bytes_max;
      // everything past the channel stats is a cycle bin
      default: sel_val = (bin_off < 8'(bin_count)) ? bin_cnt[bin_off[3:0]] : '0;
    endcase
  end

  always_comb begin
    state_next = state;
    idx_next   = idx;
    case (state)
      st_idle: begin
        if (stat_start) begin
          state_next = st_iter;
          idx_next   = '0;
        end
      end
      st_iter: begin
        if (load) begin
          idx_next = idx + 8'd1;
          if (at_last) begin
            state_next = st_idle;
          end
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= st_idle;
      stat_valid <= 1'b0;
    end else begin
      state <= state_next;
      if (load) begin
        stat_valid <= 1'b1;
      end else if (stat_ready) begin
        stat_valid <= 1'b0;
      end
    end
  end

  // payload holds until the next load
  always_ff @(posedge clk) begin
    idx <= idx_next;
    if (load) begin
      stat_id   <= stat_id_t'(idx);
      stat_val  <= sel_val;
      stat_last <= at_last;
    end
  end

endmodule

`default_nettype wire

// File: hdl/axi_wr_stats.sv
`default_nettype none

module axi_wr_stats (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stat_clear,
  input  axi_wr_stats_pkg::aw_chan_t  aw,
  input  axi_wr_stats_pkg::w_chan_t   w,
  input  axi_wr_stats_pkg::b_chan_t   b,
  input  logic                        stat_start,
  input  logic                        stat_ready,
  output logic                        stat_valid,
  output axi_wr_stats_pkg::stat_id_t  stat_id,
  output axi_wr_stats_pkg::stat_val_t stat_val,
  output logic                        stat_last
);
  import axi_wr_stats_pkg::*;

  aw_stats_t aw_s;
  w_stats_t  w_s;
  occ_t      occ;
  bins_t     bin_cnt;

  aw_stats aw_stats0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_clear (stat_clear),
    .aw         (aw),
    .stats      (aw_s)
  );

  w_stats w_stats0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_clear (stat_clear),
    .w          (w),
    .stats      (w_s)
  );

  wr_occupancy wr_occupancy0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_clear (stat_clear),
    .aw         (aw),
    .w          (w),
    .b          (b),
    .occ        (occ)
  );

  // cycle classification runs off the registered occupancy flags
  wr_cycle_bins wr_cycle_bins0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_clear (stat_clear),
    .occ        (occ),
    .aw         (aw),
    .w          (w),
    .b          (b),
    .bin_cnt    (bin_cnt)
  );

  stat_reader stat_reader0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .aw_s       (aw_s),
    .w_s        (w_s),
    .occ        (occ),
    .bin_cnt    (bin_cnt),
    .stat_start (stat_start),
    .stat_ready (stat_ready),
    .stat_valid (stat_valid),
    .stat_id    (stat_id),
    .stat_val   (stat_val),
    .stat_last  (stat_last)
  );

endmodule

`default_nettype wire

// File: bench/axi_wr_stats_properties.sv
`default_nettype none

module axi_wr_stats_properties (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        stat_valid,
  input logic                        stat_ready,
  input axi_wr_stats_pkg::stat_id_t  stat_id,
  input axi_wr_stats_pkg::stat_val_t stat_val,
  input logic                        stat_last
);

  // payload stays put while the consumer stalls
  hold_while_stalled: assert property (
    @(posedge clk) disable iff (!rst_n)
    stat_valid && !stat_ready |=>
      stat_valid && $stable(stat_id) && $stable(stat_val) && $stable(stat_last)
  ) else $error("readout item changed while stalled");

  // reader comes out of reset with nothing to offer
  reset_drops_valid: assert property (
    @(posedge clk) !rst_n |=> !stat_valid
  ) else $error("stat_valid high after reset");

endmodule

`default_nettype wire

// File: bench/axi_wr_stats_tb.sv
`default_nettype none

module axi_wr_stats_tb;
  import axi_wr_stats_pkg::*;

  localparam int traffic_cycles = 2000;
  localparam int max_stall      = 3;
  localparam int drain_limit    = 1000;
  localparam int watchdog_time  =
    (traffic_cycles + drain_limit + 4 * stat_count * (max_stall + 2) + 50) * 40 * 2;

  logic      clk;
  logic      rst_n;
  logic      stat_clear;
  aw_chan_t  aw;
  w_chan_t   w;
  b_chan_t   b;
  logic      stat_start;
  logic      stat_ready;
  logic      stat_valid;
  stat_id_t  stat_id;
  stat_val_t stat_val;
  logic      stat_last;

  logic [31:0] rng_state;
  stat_val_t   mdl [stat_count];
  stat_val_t   snap [stat_count];
  stat_val_t   m_aw_cnt;
  stat_val_t   m_w_cnt;
  logic        m_in_prog;
  stat_val_t   m_cycles;
  stat_val_t   snap_cycles;
  int          aw_pend;
  int          w_done;
  int          beats_left;
  logic [7:0]  w_q [$];

  axi_wr_stats dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_clear (stat_clear),
    .aw         (aw),
    .w          (w),
    .b          (b),
    .stat_start (stat_start),
    .stat_ready (stat_ready),
    .stat_valid (stat_valid),
    .stat_id    (stat_id),
    .stat_val   (stat_val),
    .stat_last  (stat_last)
  );

  bind axi_wr_stats axi_wr_stats_properties props0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_valid (stat_valid),
    .stat_ready (stat_ready),
    .stat_id    (stat_id),
    .stat_val   (stat_val),
    .stat_last  (stat_last)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      stop_on_failure($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  function automatic bit is_min_id(input int id);
    return id == stat_aw_len_min || id == stat_aw_bytes_min || id == stat_w_bytes_min;
  endfunction

  task automatic clear_model();
    for (int i = 0; i < stat_count; i++) begin
      mdl[i] = is_min_id(i) ? 32'hffff_ffff : 32'h0;
    end
    m_cycles = '0;
  endtask

  task automatic track_extremes(input int min_id, input int max_id, input stat_val_t v);
    if (v < mdl[min_id]) mdl[min_id] = v;
    if (v > mdl[max_id]) mdl[max_id] = v;
  endtask

  // bin index for the cycle or -1 when no rule matches
  function automatic int classify_cycle(input logic a, input logic wb, input logic p,
                                        input aw_chan_t awc, input w_chan_t wc,
                                        input b_chan_t bc);
    logic w_acc;
    logic tail;
    w_acc = wc.valid && wc.ready;
    // both halves of the write are in, waiting on the response
    tail  = a && wb && !p && !wc.valid;
    if (!a && !wb && !p && !awc.valid && !wc.valid) return int'(bin_idle);
    if (a && p && !wc.valid) return int'(bin_slow_data);
    if (wc.valid && !wc.ready && (a || p)) return int'(bin_stall);
    if (!a && !awc.valid && w_acc) return int'(bin_early_beat);
    if (!a && !wb && !p && !wc.valid && awc.valid) begin
      return awc.ready ? int'(bin_awr_early) : int'(bin_addr_stall);
    end
    if (a && !wb && !p && !wc.valid) return int'(bin_data_lag);
    if (!a && (wb || p) && !wc.valid) return int'(bin_addr_lag);
    if (!a && !p && wc.valid && !wc.ready) return int'(bin_early_stall);
    if (tail && !bc.valid) return int'(bin_b_lag);
    if (tail) return bc.ready ? int'(bin_b_end) : int'(bin_b_stall);
    return -1;
  endfunction

  // snap keeps the values the DUT samples at this edge
  always @(posedge clk) begin : model
    int        bin;
    logic      aw_acc;
    logic      w_acc;
    logic      b_acc;
    stat_val_t aw_next;
    stat_val_t w_next;
    snap        = mdl;
    snap_cycles = m_cycles;
    if (!rst_n) begin
      clear_model();
      m_aw_cnt  = '0;
      m_w_cnt   = '0;
      m_in_prog = 1'b0;
    end else begin
      aw_acc  = aw.valid && aw.ready;
      w_acc   = w.valid && w.ready;
      b_acc   = b.valid && b.ready;
      bin     = classify_cycle(m_aw_cnt != 0, m_w_cnt != 0, m_in_prog, aw, w, b);
      aw_next = m_aw_cnt + 32'(aw_acc) - 32'(b_acc);
      w_next  = m_w_cnt + 32'(w_acc && w.last) - 32'(b_acc);
      if (stat_clear) begin
        clear_model();
      end else begin
        if (aw_acc) begin
          mdl[stat_aw_burst_cnt] += 1;
          mdl[stat_aw_bytes_sum] += (32'(aw.len) + 1) << aw.size;
          track_extremes(stat_aw_len_min, stat_aw_len_max, 32'(aw.len));
          track_extremes(stat_aw_bytes_min, stat_aw_bytes_max, (32'(aw.len) + 1) << aw.size);
        end
        if (w_acc) begin
          mdl[stat_w_beat_cnt]  += 1;
          mdl[stat_w_bytes_sum] += 32'($countones(w.strb));
          track_extremes(stat_w_bytes_min, stat_w_bytes_max, 32'($countones(w.strb)));
          if (w.last) mdl[stat_w_burst_cnt] += 1;
        end
        if (aw_next > mdl[stat_aw_depth_max]) mdl[stat_aw_depth_max] = aw_next;
        if (w_next > mdl[stat_w_depth_max]) mdl[stat_w_depth_max] = w_next;
        if (bin >= 0) mdl[int'(stat_bin_idle) + bin] += 1;
        m_cycles += 1;
      end
      m_aw_cnt = aw_next;
      m_w_cnt  = w_next;
      if (w.valid) m_in_prog = !(w.ready && w.last);
    end
  end

  task automatic traffic_step(input bit issue);
    // retire what the last rising edge accepted
    if (aw.valid && aw.ready) begin
      aw.valid = 1'b0;
      aw_pend++;
    end
    if (w.valid && w.ready) begin
      beats_left--;
      if (w.last) w_done++;
      w.valid = 1'b0;
    end
    if (b.valid && b.ready) begin
      b.valid = 1'b0;
      aw_pend--;
      w_done--;
    end
    if (issue && !aw.valid && w_q.size() < 4 && aw_pend < 6 && rand32() % 3 == 0) begin
      aw.valid = 1'b1;
      aw.len   = 8'(rand32() % 16);
      aw.size  = 3'(rand32() % 3);
      w_q.push_back(aw.len);
    end
    // data may run ahead of its address
    if (!w.valid && rand32() % 4 != 0) begin
      if (beats_left == 0 && w_q.size() != 0) beats_left = int'(w_q.pop_front()) + 1;
      if (beats_left != 0) begin
        w.valid = 1'b1;
        w.strb  = 4'(rand32());
        w.last  = (beats_left == 1);
      end
    end
    if (!b.valid && aw_pend != 0 && w_done != 0 && rand32() % 2 == 0) b.valid = 1'b1;
    aw.ready = 1'(rand32());
    w.ready  = 1'(rand32());
    b.ready  = 1'(rand32());
  endtask

  task automatic drain_traffic();
    int n;
    n = 0;
    while (aw_pend != 0 || w_done != 0 || aw.valid || w.valid || b.valid
           || w_q.size() != 0 || beats_left != 0) begin
      @(negedge clk);
      traffic_step(1'b0);
      n++;
      if (n > drain_limit) stop_on_failure("outstanding writes did not drain");
    end
    aw = '0;
    w  = '0;
    b  = '0;
  endtask

  task automatic run_readout(input string tag, input bit expect_zero);
    int          item;
    int          idle_wait;
    int          stall;
    bit          fresh;
    bit          xfer;
    stat_val_t   held_val;
    logic        held_last;
    logic [31:0] bin_sum;
    item      = 0;
    idle_wait = 0;
    stall     = 0;
    fresh     = 1'b1;
    held_val  = '0;
    held_last = 1'b0;
    bin_sum   = '0;
    @(negedge clk);
    stat_start = 1'b1;
    @(negedge clk);
    stat_start = 1'b0;
    while (item < stat_count) begin
      if (!stat_valid) begin
        idle_wait++;
        if (idle_wait > 4) begin
          stop_on_failure($sformatf("%s readout stalled before id %0d", tag, item));
        end
        stat_ready = 1'b0;
      end else if (fresh) begin
        check_equal($sformatf("%s id order", tag), 32'(item), 32'(stat_id));
        check_equal($sformatf("%s value of id %0d", tag, item), snap[item], stat_val);
        check_equal($sformatf("%s last on id %0d", tag, item),
                    32'(item == stat_count - 1), 32'(stat_last));
        if (expect_zero && item < int'(stat_bin_idle)) begin
          check_equal($sformatf("%s cleared id %0d", tag, item),
                      is_min_id(item) ? 32'hffff_ffff : 32'h0, stat_val);
        end
        if (item >= int'(stat_bin_idle)) bin_sum += stat_val;
        held_val  = stat_val;
        held_last = stat_last;
        stall     = int'(rand32() % (max_stall + 1));
        fresh     = 1'b0;
      end else begin
        check_equal($sformatf("%s held id %0d", tag, item), 32'(item), 32'(stat_id));
        check_equal($sformatf("%s held value %0d", tag, item), held_val, stat_val);
        check_equal($sformatf("%s held last %0d", tag, item), 32'(held_last), 32'(stat_last));
      end
      if (stat_valid) begin
        stat_ready = (stall == 0);
        if (stall > 0) stall--;
      end
      xfer = stat_valid && stat_ready;
      @(negedge clk);
      if (xfer) begin
        item++;
        fresh     = 1'b1;
        idle_wait = 0;
      end
    end
    stat_ready = 1'b0;
    check_equal($sformatf("%s valid after last", tag), 32'h0, 32'(stat_valid));
    check_equal($sformatf("%s bin sum within cycles", tag), 32'h1, 32'(bin_sum <= snap_cycles));
  endtask

  task automatic pulse_clear();
    @(negedge clk);
    stat_clear = 1'b1;
    @(negedge clk);
    stat_clear = 1'b0;
  endtask

  initial begin
    #(watchdog_time);
    stop_on_failure("watchdog expired before the tests finished");
  end

  initial begin
    rng_state  = 32'h4118;
    aw_pend    = 0;
    w_done     = 0;
    beats_left = 0;
    rst_n      = 1'b0;
    stat_clear = 1'b0;
    stat_start = 1'b0;
    stat_ready = 1'b0;
    aw         = '0;
    w          = '0;
    b          = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_equal("valid after reset", 32'h0, 32'(stat_valid));
    run_readout("reset", 1'b1);
    repeat (traffic_cycles) begin
      @(negedge clk);
      traffic_step(1'b1);
    end
    drain_traffic();
    run_readout("traffic", 1'b0);
    run_readout("traffic repeat", 1'b0);
    pulse_clear();
    run_readout("clear", 1'b1);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hdl/axi_wr_stats_pkg.sv
hdl/aw_stats.sv
hdl/w_stats.sv
hdl/wr_occupancy.sv
hdl/wr_cycle_bins.sv
hdl/stat_reader.sv
hdl/axi_wr_stats.sv
bench/axi_wr_stats_properties.sv
bench/axi_wr_stats_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module axi_wr_stats_tb \
  -f files.f \
  -o axi_wr_stats_sim

# a failing run still prints its output before the search decides
out=$(./obj_dir/axi_wr_stats_sim 2>&1) || true
echo "$out"
grep -qx "all tests passed" <<< "$out"
